// File: mxu_top.f
source/mxu_pkg.sv
source/mxu_apb_regs.sv
source/mxu_control.sv
source/mxu_skew_feeder.sv
source/mxu_pe.sv
source/mxu_result_drain.sv
source/mxu_top.sv
verification/mxu_props.sv
verification/mxu_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing
TOP       := mxu_tb
FILELIST  := mxu_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the simulator output
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/mxu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_tb;
    import mxu_pkg::*;

    localparam int max_polls = 40;

    logic     clk;
    logic     reset;
    apb_req_t apb;
    apb_rsp_t apb_out;
    logic     done_irq;
    integer   seed;
    // operands as the host last wrote them
    int       w_ref [mxu_rows][mxu_cols];
    int       v_ref [mxu_cols];

    mxu_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .apb      (apb),
        .apb_out  (apb_out),
        .done_irq (done_irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // checks and apb access
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // setup phase, access phase, then one idle cycle
    task automatic apb_transfer(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        #1;
        apb.paddr   = addr;
        apb.pwrite  = write;
        apb.pwdata  = wdata;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        // mid-cycle, response has settled
        #4;
        check_value("pready", 32'(apb_out.pready), 32'd1);
        rdata = apb_out.prdata;
        err   = apb_out.pslverr;
        @(posedge clk);
        #1;
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] unused;
        apb_transfer(addr, 1'b1, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_transfer(addr, 1'b0, 32'h0, rdata, err);
    endtask

    // polls status until done, bounded
    task automatic wait_done;
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        st    = '0;
        while (st[1] !== 1'b1) begin
            if (polls == max_polls) begin
                $display("timed out waiting for the done flag in status");
                $display("ERRORS FOUND");
                $fatal(1, "done timeout");
            end
            apb_read(addr_status, st, err);
            polls++;
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // 32-bit dot product, wrapped to the accumulator width
    function automatic logic [31:0] dot_ref(input int row);
        int                   s;
        logic signed [acc_width-1:0] t;
        s = 0;
        for (int k = 0; k < mxu_cols; k++) begin
            s += w_ref[row][k] * v_ref[k];
        end
        t = s[acc_width-1:0];
        return 32'(t);
    endfunction

    function automatic int rand_elem();
        logic signed [7:0] b;
        b = 8'($random(seed));
        return int'(b);
    endfunction

    function automatic logic [31:0] weight_addr(input int i, input int k);
        return addr_weight_base + 32'(4 * (i * mxu_cols + k));
    endfunction

    task automatic load_operands;
        logic err;
        for (int i = 0; i < mxu_rows; i++) begin
            for (int k = 0; k < mxu_cols; k++) begin
                apb_write(weight_addr(i, k), 32'(w_ref[i][k]), err);
                check_value("pslverr on weight write", 32'(err), 32'd0);
            end
        end
        for (int k = 0; k < mxu_cols; k++) begin
            apb_write(addr_vector_base + 32'(4 * k), 32'(v_ref[k]), err);
            check_value("pslverr on vector write", 32'(err), 32'd0);
        end
    endtask

    task automatic randomize_operands;
        for (int i = 0; i < mxu_rows; i++) begin
            for (int k = 0; k < mxu_cols; k++) begin
                w_ref[i][k] = rand_elem();
            end
        end
        for (int k = 0; k < mxu_cols; k++) begin
            v_ref[k] = rand_elem();
        end
    endtask

    task automatic check_results;
        logic [31:0] rd;
        logic        err;
        apb_read(addr_status, rd, err);
        check_value("status after run", rd, 32'h2);
        check_value("done_irq", 32'(done_irq), 32'd1);
        for (int i = 0; i < mxu_rows; i++) begin
            apb_read(addr_result_base + 32'(4 * i), rd, err);
            check_value($sformatf("result[%0d]", i), rd, dot_ref(i));
        end
    endtask

    task automatic start_run;
        logic err;
        apb_write(addr_ctrl, 32'h1, err);
        check_value("pslverr on start", 32'(err), 32'd0);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic reset_state_test;
        logic [31:0] rd;
        logic        err;
        apb_read(addr_status, rd, err);
        check_value("status after reset", rd, 32'h0);
        check_value("done_irq after reset", 32'(done_irq), 32'd0);
        for (int i = 0; i < mxu_rows; i++) begin
            apb_read(addr_result_base + 32'(4 * i), rd, err);
            check_value($sformatf("result[%0d] after reset", i), rd, 32'h0);
        end
    endtask

    task automatic register_access_test;
        logic [31:0] rd;
        logic        err;
        randomize_operands();
        load_operands();
        for (int i = 0; i < mxu_rows; i++) begin
            for (int k = 0; k < mxu_cols; k++) begin
                apb_read(weight_addr(i, k), rd, err);
                check_value($sformatf("weight[%0d][%0d]", i, k), rd, 32'(w_ref[i][k]));
            end
        end
        for (int k = 0; k < mxu_cols; k++) begin
            apb_read(addr_vector_base + 32'(4 * k), rd, err);
            check_value($sformatf("vector[%0d]", k), rd, 32'(v_ref[k]));
        end
        // holes in the map
        apb_read(32'h0000_0008, rd, err);
        check_value("pslverr on unmapped read", 32'(err), 32'd1);
        apb_read(32'h0000_0100, rd, err);
        check_value("pslverr on unmapped read", 32'(err), 32'd1);
        apb_write(addr_result_base, 32'h55, err);
        check_value("pslverr on result write", 32'(err), 32'd1);
        apb_read(addr_result_base, rd, err);
        check_value("result[0] after refused write", rd, 32'h0);
    endtask

    task automatic fixed_run_test;
        w_ref = '{'{1, -2, 3}, '{-4, 5, -6}, '{7, 0, -128}};
        v_ref = '{2, -3, 4};
        load_operands();
        start_run();
        wait_done();
        check_results();
    endtask

    task automatic random_runs_test;
        for (int r = 0; r < 20; r++) begin
            randomize_operands();
            // corners first
            if (r == 0) begin
                w_ref = '{default: '{default: -128}};
                v_ref = '{default: -128};
            end else if (r == 1) begin
                w_ref = '{default: '{default: 127}};
                v_ref = '{-128, 127, -128};
            end
            load_operands();
            start_run();
            wait_done();
            check_results();
        end
    endtask

    task automatic busy_protection_test;
        logic [31:0] rd;
        logic        err;
        randomize_operands();
        load_operands();
        start_run();
        // both land while the run is in flight
        apb_write(weight_addr(0, 0), 32'(w_ref[0][0] ^ 8'h5a), err);
        check_value("pslverr on weight write while busy", 32'(err), 32'd1);
        start_run();
        wait_done();
        check_results();
        apb_read(weight_addr(0, 0), rd, err);
        check_value("weight[0][0] after refused write", rd, 32'(w_ref[0][0]));
        // a taken second start would show busy here
        apb_read(addr_status, rd, err);
        check_value("status after ignored start", rd, 32'h2);
    endtask

    task automatic back_to_back_test;
        logic [31:0] rd;
        logic        err;
        for (int r = 0; r < 2; r++) begin
            randomize_operands();
            load_operands();
            start_run();
            apb_read(addr_status, rd, err);
            check_value("status during run", rd, 32'h1);
            check_value("done_irq during run", 32'(done_irq), 32'd0);
            wait_done();
            check_results();
        end
    endtask

    //////////////////////////////
    // sequence
    //////////////////////////////

    initial begin
        seed  = 69923;
        reset = 1'b0;
        apb   = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b1;
        reset_state_test();
        register_access_test();
        fixed_run_test();
        random_runs_test();
        busy_protection_test();
        back_to_back_test();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/mxu_props.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_props (
    input logic              clk,
    input logic              reset,
    input logic              start,
    input logic              feed_go,
    input logic              busy,
    input logic              done,
    input logic              link_valid,
    input mxu_pkg::apb_req_t apb,
    input mxu_pkg::apb_rsp_t apb_out
);

    //////////////////////////////
    // control flags
    //////////////////////////////

    // done only ever follows busy, never overlaps it
    a_busy_done_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(busy && done))
        else $error("busy and done are set together");

    // chain stays silent while reset is held
    a_quiet_in_reset: assert property (@(posedge clk)
        !reset |=> (!feed_go && !link_valid))
        else $error("feed_go or link valid active during reset");

    // start, then start_ack, then load
    a_start_to_feed: assert property (@(posedge clk) disable iff (!reset)
        start |-> ##2 feed_go)
        else $error("feed_go did not follow start");

    //////////////////////////////
    // apb
    //////////////////////////////

    a_slverr_in_access: assert property (@(posedge clk)
        apb_out.pslverr |-> (apb.psel && apb.penable))
        else $error("pslverr outside the access phase");

endmodule

// control and register-file signals, seen through the top level wiring
bind mxu_top mxu_props u_props (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .feed_go    (feed_go),
    .busy       (busy),
    .done       (done),
    .link_valid (links[0].valid),
    .apb        (apb),
    .apb_out    (apb_out)
);

`default_nettype wire

// File: source/mxu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_top (
    input  logic              clk,
    input  logic              reset,
    input  mxu_pkg::apb_req_t apb,
    output mxu_pkg::apb_rsp_t apb_out,
    output logic              done_irq
);
    import mxu_pkg::*;

    logic                start;
    logic                busy;
    logic                done;
    logic                feed_go;
    logic                drain_clear;
    logic                all_rows_valid;
    vector_t             vector;
    weight_mat_t         weights;
    result_vec_t         results;
    result_vec_t         sums;
    logic [mxu_rows-1:0] sum_valids;
    // chain links, the final one runs off the end
    pe_link_t            links [0:mxu_rows];

    // host register file
    mxu_apb_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .apb     (apb),
        .apb_out (apb_out),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .vector  (vector),
        .weights (weights),
        .results (results)
    );

    mxu_control u_control (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .all_rows_valid (all_rows_valid),
        .feed_go        (feed_go),
        .drain_clear    (drain_clear),
        .busy           (busy),
        .done           (done)
    );

    mxu_skew_feeder u_feeder (
        .clk      (clk),
        .reset    (reset),
        .feed_go  (feed_go),
        .vector   (vector),
        .link_out (links[0])
    );

    //////////////////////////////
    // systolic chain
    //////////////////////////////

    for (genvar i = 0; i < mxu_rows; i++) begin : g_pe
        mxu_pe u_pe (
            .clk        (clk),
            .reset      (reset),
            .weight_row (weights[i]),
            .link_in    (links[i]),
            .link_out   (links[i+1]),
            .sum        (sums[i]),
            .sum_valid  (sum_valids[i])
        );
    end

    mxu_result_drain u_drain (
        .clk            (clk),
        .reset          (reset),
        .drain_clear    (drain_clear),
        .sums           (sums),
        .sum_valids     (sum_valids),
        .results        (results),
        .all_rows_valid (all_rows_valid)
    );

    // interrupt line mirrors the sticky done flag
    assign done_irq = done;

endmodule

`default_nettype wire

// File: source/mxu_result_drain.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_result_drain (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 drain_clear,
    input  mxu_pkg::result_vec_t sums,
    input  logic [mxu_pkg::mxu_rows-1:0] sum_valids,
    output mxu_pkg::result_vec_t results,
    output logic                 all_rows_valid
);
    import mxu_pkg::*;

    // rows captured since the last clear
    logic [mxu_rows-1:0] mask;
    logic [mxu_rows-1:0] mask_next;

    assign mask_next = mask | sum_valids;

    //////////////////////////////
    // completion tracking
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            mask           <= '0;
            all_rows_valid <= 1'b0;
        end else if (drain_clear) begin
            mask           <= '0;
            all_rows_valid <= 1'b0;
        end else begin
            mask           <= mask_next;
            // only the transition to full, never again
            all_rows_valid <= (&mask_next) & ~(&mask);
        end
    end

    //////////////////////////////
    // result capture
    //////////////////////////////

    // cleared at power-up and at every run start
    always_ff @(posedge clk) begin
        for (int i = 0; i < mxu_rows; i++) begin
            if (drain_clear) begin
                results[i] <= '0;
            end else if (sum_valids[i]) begin
                results[i] <= sums[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mxu_pe.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_pe (
    input  logic                 clk,
    input  logic                 reset,
    input  mxu_pkg::weight_row_t weight_row,
    input  mxu_pkg::pe_link_t    link_in,
    output mxu_pkg::pe_link_t    link_out,
    output mxu_pkg::acc_t        sum,
    output logic                 sum_valid
);
    import mxu_pkg::*;

    elem_t                         w_sel;
    logic signed [2*data_width-1:0] prod;
    acc_t                          acc;

    //////////////////////////////
    // multiply
    //////////////////////////////

    // weight column picked by the element index
    assign w_sel = weight_row[link_in.idx];
    // full-precision signed product
    assign prod  = w_sel * link_in.x;

    //////////////////////////////
    // accumulate
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (link_in.valid) begin
            // index 0 opens a fresh dot product
            if (link_in.idx == '0) begin
                acc <= acc_width'(prod);
            end else begin
                acc <= acc + acc_width'(prod);
            end
        end
    end

    // pulse once the final term has landed in acc
    always_ff @(posedge clk) begin
        if (!reset) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= link_in.valid & link_in.last;
        end
    end

    assign sum = acc;

    //////////////////////////////
    // link pass-through
    //////////////////////////////

    // one register stage per element gives the skew
    always_ff @(posedge clk) begin
        if (!reset) begin
            link_out.valid <= 1'b0;
        end else begin
            link_out.valid <= link_in.valid;
        end
        link_out.last <= link_in.last;
        link_out.idx  <= link_in.idx;
        link_out.x    <= link_in.x;
    end

endmodule

`default_nettype wire

// File: source/mxu_skew_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_skew_feeder (
    input  logic              clk,
    input  logic              reset,
    input  logic              feed_go,
    input  mxu_pkg::vector_t  vector,
    output mxu_pkg::pe_link_t link_out
);
    import mxu_pkg::*;

    // walking state after element 0
    logic                 run;
    logic [idx_width-1:0] idx_q;
    vector_t              vec_q;
    logic                 at_last;

    assign at_last = (idx_q == idx_width'(mxu_cols - 1));

    //////////////////////////////
    // element stream
    //////////////////////////////

    // element 0 goes out with feed_go, the rest from the snapshot
    always_comb begin
        link_out = '0;
        if (feed_go) begin
            link_out.valid = 1'b1;
            link_out.last  = (mxu_cols == 1);
            link_out.idx   = '0;
            link_out.x     = vector[0];
        end else if (run) begin
            link_out.valid = 1'b1;
            link_out.last  = at_last;
            link_out.idx   = idx_q;
            link_out.x     = vec_q[idx_q];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            run   <= 1'b0;
            idx_q <= '0;
        end else if (feed_go) begin
            run   <= (mxu_cols > 1);
            idx_q <= idx_width'(1);
        end else if (run) begin
            // stop after the last index
            run   <= ~at_last;
            idx_q <= idx_q + idx_width'(1);
        end
    end

    // snapshot so host writes after the run cannot disturb it
    always_ff @(posedge clk) begin
        if (feed_go) begin
            vec_q <= vector;
        end
    end

endmodule

`default_nettype wire

// File: source/mxu_control.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_control (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic all_rows_valid,
    output logic feed_go,
    output logic drain_clear,
    output logic busy,
    output logic done
);
    import mxu_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    // start is only taken while no run is in flight
    logic        start_take;
    logic        run_end;

    assign start_take = start & ((state == st_idle) | (state == st_done));
    assign run_end    = (state == st_compute) & all_rows_valid;

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            // one cycle to wipe the result registers
            st_power_up: begin
                state_next = st_idle;
            end
            st_idle: begin
                if (start_take) begin
                    state_next = st_start_ack;
                end
            end
            // handshake cycle, operands are locked from here
            st_start_ack: begin
                state_next = st_load;
            end
            // kick the feeder, clear the drain
            st_load: begin
                state_next = st_compute;
            end
            // chain runs freely, the drain reports completion
            st_compute: begin
                if (all_rows_valid) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                if (start_take) begin
                    state_next = st_start_ack;
                end else begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_power_up;
            end
        endcase
    end

    //////////////////////////////
    // state and status flags
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= st_power_up;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            if (start_take) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (run_end) begin
                // busy and done swap on the same edge
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // single-cycle strobes decoded from state
    assign feed_go     = (state == st_load);
    assign drain_clear = (state == st_power_up) | (state == st_load);

endmodule

`default_nettype wire

// File: source/mxu_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_apb_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  mxu_pkg::apb_req_t    apb,
    output mxu_pkg::apb_rsp_t    apb_out,
    output logic                 start,
    input  logic                 busy,
    input  logic                 done,
    output mxu_pkg::vector_t     vector,
    output mxu_pkg::weight_mat_t weights,
    input  mxu_pkg::result_vec_t results
);
    import mxu_pkg::*;

    // access phase of any transfer
    logic                              access;
    logic                              hit_ctrl;
    logic                              hit_status;
    logic                              hit_weight;
    logic                              hit_vector;
    logic                              hit_result;
    logic [mxu_rows-1:0][mxu_cols-1:0] sel_weight;
    logic [mxu_cols-1:0]               sel_vector;
    logic [mxu_rows-1:0]               sel_result;
    logic                              err;
    logic                              wr_ok;
    logic [31:0]                       rdata;

    assign access = apb.psel & apb.penable;

    //////////////////////////////
    // address decode
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < mxu_rows; i++) begin
            for (int k = 0; k < mxu_cols; k++) begin
                sel_weight[i][k] = (apb.paddr == addr_weight_base + 32'(4 * (i * mxu_cols + k)));
            end
            sel_result[i] = (apb.paddr == addr_result_base + 32'(4 * i));
        end
        for (int k = 0; k < mxu_cols; k++) begin
            sel_vector[k] = (apb.paddr == addr_vector_base + 32'(4 * k));
        end
    end

    assign hit_ctrl   = (apb.paddr == addr_ctrl);
    assign hit_status = (apb.paddr == addr_status);
    assign hit_weight = |sel_weight;
    assign hit_vector = |sel_vector;
    assign hit_result = |sel_result;

    // unmapped, result write, or operand write mid-run
    assign err = ~(hit_ctrl | hit_status | hit_weight | hit_vector | hit_result)
               | (apb.pwrite & hit_result)
               | (apb.pwrite & busy & (hit_weight | hit_vector));

    // erroring writes are dropped entirely
    assign wr_ok = access & apb.pwrite & ~err;

    //////////////////////////////
    // read mux
    //////////////////////////////

    always_comb begin
        rdata = '0;
        if (hit_status) begin
            rdata[1:0] = {done, busy};
        end
        // operands and sums come back sign extended
        for (int i = 0; i < mxu_rows; i++) begin
            for (int k = 0; k < mxu_cols; k++) begin
                if (sel_weight[i][k]) begin
                    rdata = 32'(weights[i][k]);
                end
            end
            if (sel_result[i]) begin
                rdata = 32'(results[i]);
            end
        end
        for (int k = 0; k < mxu_cols; k++) begin
            if (sel_vector[k]) begin
                rdata = 32'(vector[k]);
            end
        end
    end

    // zero wait states
    assign apb_out.prdata  = rdata;
    assign apb_out.pready  = 1'b1;
    assign apb_out.pslverr = access & err;

    //////////////////////////////
    // operand storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < mxu_rows; i++) begin
            for (int k = 0; k < mxu_cols; k++) begin
                if (wr_ok && sel_weight[i][k]) begin
                    weights[i][k] <= apb.pwdata[data_width-1:0];
                end
            end
        end
        for (int k = 0; k < mxu_cols; k++) begin
            if (wr_ok && sel_vector[k]) begin
                vector[k] <= apb.pwdata[data_width-1:0];
            end
        end
    end

    // start pulse, one cycle after the access phase
    // a start during a run is simply lost
    always_ff @(posedge clk) begin
        if (!reset) begin
            start <= 1'b0;
        end else begin
            start <= wr_ok & hit_ctrl & apb.pwdata[0] & ~busy;
        end
    end

endmodule

`default_nettype wire

// File: source/mxu_pkg.sv
`default_nettype none

package mxu_pkg;

    //////////////////////////////
    // array sizes
    //////////////////////////////

    // one processing element per matrix row
    localparam int mxu_rows   = 3;
    localparam int mxu_cols   = 3;
    localparam int data_width = 8;
    // 3 terms of 8x8 products fit with headroom
    localparam int acc_width  = 20;
    localparam int idx_width  = $clog2(mxu_cols);

    //////////////////////////////
    // register map, byte addresses
    //////////////////////////////

    localparam logic [31:0] addr_ctrl        = 32'h0000_0000;
    localparam logic [31:0] addr_status      = 32'h0000_0004;
    // row-major, one word per weight
    localparam logic [31:0] addr_weight_base = 32'h0000_0010;
    localparam logic [31:0] addr_vector_base = 32'h0000_0040;
    // read-only sums
    localparam logic [31:0] addr_result_base = 32'h0000_0060;

    //////////////////////////////
    // operand and result types
    //////////////////////////////

    typedef logic signed [data_width-1:0] elem_t;
    typedef logic signed [acc_width-1:0]  acc_t;

    typedef elem_t       [mxu_cols-1:0] weight_row_t;
    typedef elem_t       [mxu_cols-1:0] vector_t;
    typedef weight_row_t [mxu_rows-1:0] weight_mat_t;
    typedef acc_t        [mxu_rows-1:0] result_vec_t;

    // apb host to slave
    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb slave to host
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // one vector element travelling down the chain
    typedef struct packed {
        logic                 valid;
        logic                 last;
        logic [idx_width-1:0] idx;
        elem_t                x;
    } pe_link_t;

    // run sequencing
    typedef enum logic [3:0] {
        st_power_up  = 4'h0,
        st_idle      = 4'h1,
        st_start_ack = 4'h2,
        st_load      = 4'h3,
        st_compute   = 4'h4,
        st_done      = 4'h5
    } ctrl_state_t;

endpackage

`default_nettype wire
